// ==== include/mastermind_config.svh ====
`ifndef MASTERMIND_CONFIG_SVH
`define MASTERMIND_CONFIG_SVH

// board game geometry
`define MM_PEGS            4
`define MM_COLOR_W         3
`define MM_MAX_TURNS       8
`define MM_TURN_W          3

// timing dividers, short values for simulation
`define MM_DEBOUNCE_CYCLES 16   // stable cycles before a press counts
`define MM_BLINK_DIV       64   // cycles per blink phase
`define MM_SCAN_DIV        8    // cycles per digit

// host register map, 5 bit byte addresses
`define MM_REG_CTRL        5'h00
`define MM_REG_CODE        5'h04
`define MM_REG_STATUS      5'h08
`define MM_REG_HIST_SEL    5'h0C
`define MM_REG_HIST_DATA   5'h10

`define MM_LFSR_TAPS       16'hB400 // galois taps 16,14,13,11

`endif

// ==== design/mastermind_pkg.sv ====
`include "mastermind_config.svh"

package mastermind_pkg;

    typedef logic [`MM_COLOR_W-1:0] color_t; // one peg colour, 8 values

    // secret code or guess, host sees raw word, core indexes pegs
    typedef union packed {
        logic [`MM_PEGS*`MM_COLOR_W-1:0] raw;
        color_t [`MM_PEGS-1:0]           pegs; // peg 0 in bits 2:0
    } code_u;

    typedef struct packed {
        logic [2:0] exact;   // right colour, right place
        logic [2:0] partial; // right colour, wrong place
    } feedback_t;

    // register block to core
    typedef struct packed {
        logic  new_game; // single cycle strobe
        logic  use_lfsr;
        logic  blink_en;
        code_u code;     // active secret code
    } game_ctrl_t;

    // core back to register block
    typedef struct packed {
        logic [`MM_TURN_W-1:0] turn;
        feedback_t             last_fb;
        logic                  won;
        logic                  lost;
        logic                  game_over; // won | lost
    } game_status_t;

endpackage

// ==== design/button_pulse.sv ====
`timescale 1ns/100ps
`include "mastermind_config.svh"

module button_pulse (
    input  logic clk,
    input  logic arst_n,
    input  logic btn,   // raw, async to clk
    output logic press  // one cycle per press
);

    localparam int CNT_W = $clog2(`MM_DEBOUNCE_CYCLES + 1);

    logic             sync1, sync2; // metastability chain
    logic             level;        // debounced level
    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sync1 <= 1'b0;
            sync2 <= 1'b0;
            level <= 1'b0;
            cnt   <= '0;
            press <= 1'b0;
        end else begin
            sync1 <= btn;
            sync2 <= sync1;
            press <= 1'b0;
            if (sync2 == level) begin
                cnt <= '0; // bounce or idle, restart
            end else if (cnt == CNT_W'(`MM_DEBOUNCE_CYCLES - 1)) begin
                cnt   <= '0;
                level <= sync2;
                press <= sync2; // rising level only
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

// ==== design/guess_entry.sv ====
`timescale 1ns/100ps

module guess_entry (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  enable, // edit mode, switch down
    input  logic                  left,
    input  logic                  right,
    input  logic                  up,
    input  logic                  down,
    input  logic                  clear,  // new game or submitted guess
    output mastermind_pkg::code_u guess,
    output logic [1:0]            cursor
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            guess  <= '0;
            cursor <= '0;
        end else if (clear) begin
            guess  <= '0; // all pegs back to colour 0
            cursor <= '0;
        end else if (enable) begin
            // 2 bit cursor wraps on its own
            if (right) begin
                cursor <= cursor + 1'b1;
            end else if (left) begin
                cursor <= cursor - 1'b1;
            end
            // colour steps mod 8 through natural overflow
            if (up) begin
                guess.pegs[cursor] <= guess.pegs[cursor] + 1'b1;
            end else if (down) begin
                guess.pegs[cursor] <= guess.pegs[cursor] - 1'b1;
            end
        end
    end

endmodule

// ==== design/game_regs.sv ====
`timescale 1ns/100ps
`include "mastermind_config.svh"

module game_regs (
    input  logic                         clk,
    input  logic                         arst_n,
    // axi4-lite slave
    input  logic [4:0]                   s_awaddr,
    input  logic                         s_awvalid,
    output logic                         s_awready,
    input  logic [31:0]                  s_wdata,
    input  logic                         s_wvalid,
    output logic                         s_wready,
    output logic [1:0]                   s_bresp,
    output logic                         s_bvalid,
    input  logic                         s_bready,
    input  logic [4:0]                   s_araddr,
    input  logic                         s_arvalid,
    output logic                         s_arready,
    output logic [31:0]                  s_rdata,
    output logic [1:0]                   s_rresp,
    output logic                         s_rvalid,
    input  logic                         s_rready,
    // game core side
    output mastermind_pkg::game_ctrl_t   ctrl,
    input  mastermind_pkg::game_status_t status,
    output logic [`MM_TURN_W-1:0]        hist_sel,
    input  mastermind_pkg::code_u        hist_data,
    input  mastermind_pkg::feedback_t    hist_fb
);

    logic [15:0] lfsr;     // free running code source
    logic [11:0] code_wr;  // last host written code
    logic        wr_go, wr_fire, ar_go;
    logic [31:0] rd_mux;

    assign s_bresp = 2'b00; // always okay
    assign s_rresp = 2'b00;

    // ready pulses once both channels are valid and no response pending
    assign wr_go   = s_awvalid && s_wvalid && !s_awready && !s_bvalid;
    assign wr_fire = s_awready && s_awvalid && s_wvalid;
    assign ar_go   = s_arvalid && !s_arready && !s_rvalid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lfsr <= 16'hACE1; // any nonzero seed
        end else begin
            lfsr <= lfsr[0] ? ((lfsr >> 1) ^ `MM_LFSR_TAPS) : (lfsr >> 1);
        end
    end

    // write channel and control registers
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s_awready     <= 1'b0;
            s_wready      <= 1'b0;
            s_bvalid      <= 1'b0;
            ctrl          <= '0;
            ctrl.blink_en <= 1'b1; // blinking on out of reset
            code_wr       <= '0;
            hist_sel      <= '0;
        end else begin
            s_awready     <= wr_go;
            s_wready      <= wr_go;
            ctrl.new_game <= 1'b0; // strobe
            if (wr_fire) begin
                s_bvalid <= 1'b1;
                case (s_awaddr)
                    `MM_REG_CTRL: begin
                        ctrl.new_game <= s_wdata[0];
                        ctrl.use_lfsr <= s_wdata[1];
                        ctrl.blink_en <= s_wdata[2];
                        if (s_wdata[0]) begin // new game picks the code source
                            ctrl.code.raw <= s_wdata[1] ? lfsr[11:0] : code_wr;
                        end
                    end
                    `MM_REG_CODE: begin
                        code_wr       <= s_wdata[11:0];
                        ctrl.code.raw <= s_wdata[11:0];
                    end
                    `MM_REG_HIST_SEL: hist_sel <= s_wdata[`MM_TURN_W-1:0];
                    default: ; // status, hist_data read only
                endcase
            end else if (s_bready) begin
                s_bvalid <= 1'b0;
            end
        end
    end

    always_comb begin
        case (s_araddr)
            `MM_REG_CTRL:      rd_mux = {29'b0, ctrl.blink_en, ctrl.use_lfsr, 1'b0};
            `MM_REG_CODE:      rd_mux = 32'(ctrl.code.raw);
            `MM_REG_STATUS:    rd_mux = 32'(status);
            `MM_REG_HIST_SEL:  rd_mux = 32'(hist_sel);
            `MM_REG_HIST_DATA: rd_mux = 32'({hist_fb, hist_data.raw}); // fb in 17:12
            default:           rd_mux = '0;
        endcase
    end

    // read channel
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s_arready <= 1'b0;
            s_rvalid  <= 1'b0;
        end else begin
            s_arready <= ar_go;
            if (s_arready && s_arvalid) begin
                s_rvalid <= 1'b1;
            end else if (s_rready) begin
                s_rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s_arready && s_arvalid) begin
            s_rdata <= rd_mux; // held until rready
        end
    end

endmodule

// ==== design/game_core.sv ====
`timescale 1ns/100ps
`include "mastermind_config.svh"

module game_core (
    input  logic                         clk,
    input  logic                         arst_n,
    input  mastermind_pkg::game_ctrl_t   ctrl,
    output mastermind_pkg::game_status_t status,
    input  logic                         select,
    input  logic                         mode,   // high to browse history
    input  logic                         up,
    input  logic                         down,
    input  mastermind_pkg::code_u        guess,
    input  logic [`MM_TURN_W-1:0]        hist_sel,
    output mastermind_pkg::code_u        hist_data,
    output mastermind_pkg::feedback_t    hist_fb,
    output mastermind_pkg::code_u        show_code,
    output mastermind_pkg::feedback_t    show_fb,
    output logic [`MM_MAX_TURNS-1:0]     turn_onehot
);

    import mastermind_pkg::*;

    localparam logic [`MM_TURN_W-1:0] LAST_TURN = `MM_TURN_W'(`MM_MAX_TURNS - 1);

    code_u                   hist_guess [`MM_MAX_TURNS]; // guess of each turn
    feedback_t               hist_score [`MM_MAX_TURNS];
    logic [`MM_MAX_TURNS-1:0] hist_valid;
    logic [`MM_TURN_W-1:0]   rev_ptr;   // browsed turn
    feedback_t               fb_now;
    logic                    take;

    // exact matches, then colour overlap minus exact
    function automatic feedback_t score(input code_u g, input code_u c);
        feedback_t  fb;
        logic [2:0] ex, common, ng, nc;
        ex     = '0;
        common = '0;
        for (int i = 0; i < `MM_PEGS; i++) begin
            ex += 3'(g.pegs[i] == c.pegs[i]);
        end
        for (int col = 0; col < (1 << `MM_COLOR_W); col++) begin
            ng = '0;
            nc = '0;
            for (int i = 0; i < `MM_PEGS; i++) begin
                ng += 3'(g.pegs[i] == color_t'(col));
                nc += 3'(c.pegs[i] == color_t'(col));
            end
            common += (ng < nc) ? ng : nc; // min of occurrences
        end
        fb.exact   = ex;
        fb.partial = common - ex;
        return fb;
    endfunction

    assign fb_now = score(guess, ctrl.code);
    assign take   = select && !mode && !status.game_over;

    always_ff @(posedge clk) begin
        if (take) begin
            hist_guess[status.turn] <= guess;
            hist_score[status.turn] <= fb_now;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            status     <= '0;
            hist_valid <= '0;
            rev_ptr    <= '0;
        end else if (ctrl.new_game) begin
            status     <= '0; // fresh board
            hist_valid <= '0;
            rev_ptr    <= '0;
        end else begin
            if (take) begin
                hist_valid[status.turn] <= 1'b1;
                status.last_fb          <= fb_now;
                if (status.turn != LAST_TURN) begin
                    status.turn <= status.turn + 1'b1; // saturates on the last slot
                end
                if (fb_now.exact == 3'(`MM_PEGS)) begin
                    status.won       <= 1'b1;
                    status.game_over <= 1'b1;
                end else if (status.turn == LAST_TURN) begin
                    status.lost      <= 1'b1; // out of turns
                    status.game_over <= 1'b1;
                end
            end
            // browse only over stored turns
            if (mode && up && rev_ptr != LAST_TURN && hist_valid[rev_ptr + 1'b1]) begin
                rev_ptr <= rev_ptr + 1'b1;
            end else if (mode && down && rev_ptr != '0) begin
                rev_ptr <= rev_ptr - 1'b1;
            end
        end
    end

    // host history port
    assign hist_data = hist_valid[hist_sel] ? hist_guess[hist_sel] : '0;
    assign hist_fb   = hist_valid[hist_sel] ? hist_score[hist_sel] : '0;

    always_comb begin
        if (mode) begin
            show_code = hist_valid[rev_ptr] ? hist_guess[rev_ptr] : '0;
            show_fb   = hist_valid[rev_ptr] ? hist_score[rev_ptr] : '0;
        end else begin
            show_code = guess;          // live edit
            show_fb   = status.last_fb;
        end
    end

    assign turn_onehot = `MM_MAX_TURNS'(1) << status.turn;

endmodule

// ==== design/display_driver.sv ====
`timescale 1ns/100ps
`include "mastermind_config.svh"

module display_driver (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      blink_en,
    input  logic                      mode,
    input  logic [1:0]                cursor,
    input  mastermind_pkg::code_u     show_code,
    input  mastermind_pkg::feedback_t show_fb,
    input  logic [`MM_MAX_TURNS-1:0]  turn_onehot,
    output logic [7:0]                seg,   // dp + g..a, active low
    output logic [3:0]                an,    // active low
    output logic [2:0]                rgb0_out,
    output logic [2:0]                rgb1_out,
    output logic [2:0]                rgb2_out,
    output logic [2:0]                rgb3_out,
    output logic [7:0]                sw_led
);

    localparam int BLINK_W = $clog2(`MM_BLINK_DIV);
    localparam int SCAN_W  = $clog2(`MM_SCAN_DIV);

    logic [BLINK_W-1:0] blink_cnt;
    logic [SCAN_W-1:0]  scan_cnt;
    logic               phase;    // low is the dark half
    logic [1:0]         digit;
    logic               scan_on;  // anodes stay off until first tick
    logic               dark;
    logic [2:0]         rgb [`MM_PEGS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            blink_cnt <= '0;
            scan_cnt  <= '0;
            phase     <= 1'b1;
            digit     <= '0;
            scan_on   <= 1'b0;
        end else begin
            blink_cnt <= (blink_cnt == BLINK_W'(`MM_BLINK_DIV - 1)) ? '0 : blink_cnt + 1'b1;
            scan_cnt  <= (scan_cnt == SCAN_W'(`MM_SCAN_DIV - 1)) ? '0 : scan_cnt + 1'b1;
            if (blink_cnt == BLINK_W'(`MM_BLINK_DIV - 1)) phase <= !phase; // blink tick
            if (scan_cnt == SCAN_W'(`MM_SCAN_DIV - 1)) begin                // scan tick
                scan_on <= 1'b1;
                digit   <= scan_on ? digit + 1'b1 : '0;
            end
        end
    end

    function automatic logic [6:0] seg7(input logic [2:0] n);
        case (n) // gfedcba, 0 lights
            3'd0:    return 7'b1000000;
            3'd1:    return 7'b1111001;
            3'd2:    return 7'b0100100;
            3'd3:    return 7'b0110000;
            3'd4:    return 7'b0011001;
            3'd5:    return 7'b0010010;
            3'd6:    return 7'b0000010;
            default: return 7'b1111000; // 7
        endcase
    endfunction

    assign an = scan_on ? ~(4'b0001 << digit) : 4'hF;

    always_comb begin
        case (digit)
            2'd3:    seg = {1'b1, seg7(show_fb.exact)};
            2'd2:    seg = {1'b1, seg7(show_fb.partial)};
            default: seg = 8'hFF; // blank
        endcase
    end

    // selected peg goes dark in the off phase while editing
    assign dark = blink_en && !mode && !phase;

    always_comb begin
        for (int i = 0; i < `MM_PEGS; i++) begin
            rgb[i] = (dark && cursor == 2'(i)) ? 3'b000 : show_code.pegs[i];
        end
    end

    assign rgb0_out = rgb[0];
    assign rgb1_out = rgb[1];
    assign rgb2_out = rgb[2];
    assign rgb3_out = rgb[3];
    assign sw_led   = 8'(turn_onehot); // one-hot turn above the switches

endmodule

// ==== design/mastermind.sv ====
`timescale 1ns/100ps
`include "mastermind_config.svh"

module mastermind (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        sw,        // mode, up to browse history
    input  logic        btn_s,     // select
    input  logic        btn_r,
    input  logic        btn_l,
    input  logic        btn_u,
    input  logic        btn_d,
    input  logic [4:0]  s_awaddr,
    input  logic        s_awvalid,
    output logic        s_awready,
    input  logic [31:0] s_wdata,
    input  logic        s_wvalid,
    output logic        s_wready,
    output logic [1:0]  s_bresp,
    output logic        s_bvalid,
    input  logic        s_bready,
    input  logic [4:0]  s_araddr,
    input  logic        s_arvalid,
    output logic        s_arready,
    output logic [31:0] s_rdata,
    output logic [1:0]  s_rresp,
    output logic        s_rvalid,
    input  logic        s_rready,
    output logic [7:0]  seg,
    output logic [3:0]  an,
    output logic [2:0]  rgb0_out,
    output logic [2:0]  rgb1_out,
    output logic [2:0]  rgb2_out,
    output logic [2:0]  rgb3_out,
    output logic [7:0]  sw_led
);

    import mastermind_pkg::*;

    logic [4:0]               btn_raw, press; // d, u, l, r, s
    logic [1:0]               cursor;
    logic [`MM_TURN_W-1:0]    hist_sel;
    logic [`MM_MAX_TURNS-1:0] turn_onehot;
    code_u                    guess, hist_data, show_code;
    feedback_t                hist_fb, show_fb;
    game_ctrl_t               ctrl;
    game_status_t             status;

    assign btn_raw = {btn_d, btn_u, btn_l, btn_r, btn_s};

    for (genvar i = 0; i < 5; i++) begin : g_btn
        button_pulse btn_i (.clk(clk), .arst_n(arst_n), .btn(btn_raw[i]), .press(press[i]));
    end

    guess_entry guess_i (
        .clk(clk), .arst_n(arst_n),
        .enable(!sw),
        .left(press[2]), .right(press[1]), .up(press[3]), .down(press[4]),
        .clear(ctrl.new_game || press[0]), // fresh guess after submit
        .guess(guess), .cursor(cursor)
    );

    game_regs regs_i (
        .clk(clk), .arst_n(arst_n),
        .s_awaddr(s_awaddr), .s_awvalid(s_awvalid), .s_awready(s_awready),
        .s_wdata(s_wdata), .s_wvalid(s_wvalid), .s_wready(s_wready),
        .s_bresp(s_bresp), .s_bvalid(s_bvalid), .s_bready(s_bready),
        .s_araddr(s_araddr), .s_arvalid(s_arvalid), .s_arready(s_arready),
        .s_rdata(s_rdata), .s_rresp(s_rresp), .s_rvalid(s_rvalid), .s_rready(s_rready),
        .ctrl(ctrl), .status(status),
        .hist_sel(hist_sel), .hist_data(hist_data), .hist_fb(hist_fb)
    );

    game_core core_i (
        .clk(clk), .arst_n(arst_n), .ctrl(ctrl), .status(status),
        .select(press[0]), .mode(sw), .up(press[3]), .down(press[4]),
        .guess(guess), .hist_sel(hist_sel), .hist_data(hist_data), .hist_fb(hist_fb),
        .show_code(show_code), .show_fb(show_fb), .turn_onehot(turn_onehot)
    );

    display_driver disp_i (
        .clk(clk), .arst_n(arst_n),
        .blink_en(ctrl.blink_en), .mode(sw), .cursor(cursor),
        .show_code(show_code), .show_fb(show_fb), .turn_onehot(turn_onehot),
        .seg(seg), .an(an),
        .rgb0_out(rgb0_out), .rgb1_out(rgb1_out), .rgb2_out(rgb2_out), .rgb3_out(rgb3_out),
        .sw_led(sw_led)
    );

endmodule

// ==== sim/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk; // 4 ns period
    end

    initial begin
        arst_n = 1'b0;
        repeat (5) @(posedge clk);
        #1 arst_n = 1'b1; // release off the edge
    end

endmodule

// ==== sim/tb_mastermind.sv ====
`timescale 1ns/100ps
`include "mastermind_config.svh"

module tb_mastermind;

    localparam int TIMEOUT = 200;                     // cycles per wait loop
    localparam int HOLD    = `MM_DEBOUNCE_CYCLES + 4; // press and release time
    localparam int K_SEL = 0, K_RIGHT = 1, K_LEFT = 2, K_UP = 3, K_DOWN = 4;

    logic        clk, arst_n, sw;
    logic [4:0]  btn;                 // d, u, l, r, s
    logic [4:0]  s_awaddr, s_araddr;
    logic [31:0] s_wdata, s_rdata;
    logic        s_awvalid, s_awready, s_wvalid, s_wready, s_bvalid, s_bready;
    logic        s_arvalid, s_arready, s_rvalid, s_rready;
    logic [1:0]  s_bresp, s_rresp;
    logic [7:0]  seg, sw_led;
    logic [3:0]  an;
    logic [2:0]  rgb0_out, rgb1_out, rgb2_out, rgb3_out;

    logic [11:0] guess_m;             // model of the edited guess
    logic [1:0]  cursor_m;
    logic [11:0] hist_g [8];          // guesses of the lost game
    logic [5:0]  hist_f [8];
    logic [31:0] rng;
    string       test_name;

    tb_clock clk_i (.clk(clk), .arst_n(arst_n));

    mastermind dut_i (
        .clk(clk), .arst_n(arst_n), .sw(sw),
        .btn_s(btn[0]), .btn_r(btn[1]), .btn_l(btn[2]), .btn_u(btn[3]), .btn_d(btn[4]),
        .s_awaddr(s_awaddr), .s_awvalid(s_awvalid), .s_awready(s_awready),
        .s_wdata(s_wdata), .s_wvalid(s_wvalid), .s_wready(s_wready),
        .s_bresp(s_bresp), .s_bvalid(s_bvalid), .s_bready(s_bready),
        .s_araddr(s_araddr), .s_arvalid(s_arvalid), .s_arready(s_arready),
        .s_rdata(s_rdata), .s_rresp(s_rresp), .s_rvalid(s_rvalid), .s_rready(s_rready),
        .seg(seg), .an(an), .rgb0_out(rgb0_out), .rgb1_out(rgb1_out),
        .rgb2_out(rgb2_out), .rgb3_out(rgb3_out), .sw_led(sw_led)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // pair each peg at most once, exact pairs first
    function automatic logic [5:0] ref_score(input logic [11:0] g, input logic [11:0] c);
        int ex;
        int part;
        bit used_g [4];
        bit used_c [4];
        ex   = 0;
        part = 0;
        for (int i = 0; i < 4; i++) begin
            used_g[i] = g[3*i +: 3] == c[3*i +: 3];
            used_c[i] = used_g[i];
            ex += int'(used_g[i]);
        end
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                if (!used_g[i] && !used_c[j] && g[3*i +: 3] == c[3*j +: 3]) begin
                    used_g[i] = 1'b1; // colour-only hit
                    used_c[j] = 1'b1;
                    part++;
                end
            end
        end
        return {3'(ex), 3'(part)};
    endfunction

    // dp then gfedcba, low lights a segment
    function automatic logic [7:0] seg_code(input logic [2:0] n);
        case (n)
            3'd0:    return 8'hC0;
            3'd1:    return 8'hF9;
            3'd2:    return 8'hA4;
            3'd3:    return 8'hB0;
            3'd4:    return 8'h99;
            3'd5:    return 8'h92;
            3'd6:    return 8'h82;
            default: return 8'hF8;
        endcase
    endfunction

    task automatic fail_now(input string msg);
        $display("%s during test %s", msg, test_name);
        $display("TB FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
            $display("TB FAILED");
            $fatal(1, "first mismatch");
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1; // drive and sample away from the edge
    endtask

    task automatic axi_write(input logic [4:0] addr, input logic [31:0] data);
        int n;
        s_awaddr  = addr;
        s_wdata   = data;
        s_awvalid = 1'b1;
        s_wvalid  = 1'b1;
        n = 0;
        while (!(s_awready && s_wready)) begin
            next_cycle();
            n++;
            if (n > TIMEOUT) fail_now("write address and data never accepted");
        end
        next_cycle();  // handshake edge
        s_awvalid = 1'b0;
        s_wvalid  = 1'b0;
        s_bready  = 1'b1;
        n = 0;
        while (!s_bvalid) begin
            next_cycle();
            n++;
            if (n > TIMEOUT) fail_now("write response never came");
        end
        check_value("bresp", 32'd0, s_bresp);
        next_cycle();
        s_bready = 1'b0;
    endtask

    task automatic axi_read(input logic [4:0] addr, output logic [31:0] data);
        int n;
        s_araddr  = addr;
        s_arvalid = 1'b1;
        n = 0;
        while (!s_arready) begin
            next_cycle();
            n++;
            if (n > TIMEOUT) fail_now("read address never accepted");
        end
        next_cycle();
        s_arvalid = 1'b0;
        n = 0;
        while (!s_rvalid) begin
            next_cycle();
            n++;
            if (n > TIMEOUT) fail_now("read data never came");
        end
        data = s_rdata; // held while rvalid
        check_value("rresp", 32'd0, s_rresp);
        s_rready = 1'b1;
        next_cycle();
        s_rready = 1'b0;
    endtask

    task automatic press_button(input int k);
        btn[k] = 1'b1;
        repeat (HOLD) next_cycle(); // pulse and edit land inside the hold
        btn[k] = 1'b0;
        repeat (HOLD) next_cycle();
    endtask

    // press plus guess model update
    task automatic press_key(input int k);
        press_button(k);
        if (k == K_SEL) begin
            guess_m  = '0;  // submit clears the entry
            cursor_m = '0;
        end else if (!sw) begin
            case (k)
                K_RIGHT: cursor_m = cursor_m + 2'd1;
                K_LEFT:  cursor_m = cursor_m - 2'd1;
                K_UP:    guess_m[3*cursor_m +: 3] = guess_m[3*cursor_m +: 3] + 3'd1;
                default: guess_m[3*cursor_m +: 3] = guess_m[3*cursor_m +: 3] - 3'd1;
            endcase
        end
    endtask

    task automatic check_leds(input logic [11:0] exp);
        check_value("leds", exp, {rgb3_out, rgb2_out, rgb1_out, rgb0_out});
    endtask

    // shortest way round for each peg
    task automatic enter_guess(input logic [11:0] g);
        logic [2:0] diff;
        for (int p = 0; p < 4; p++) begin
            while (cursor_m != 2'(p)) press_key(K_RIGHT);
            diff = g[3*p +: 3] - guess_m[3*p +: 3];
            if (diff <= 3'd4) repeat (diff) press_key(K_UP);
            else repeat (4'd8 - diff) press_key(K_DOWN);
        end
        check_leds(g);
    endtask

    task automatic wait_anode(input logic [3:0] pattern);
        int n;
        n = 0;
        while (an !== pattern) begin
            next_cycle();
            n++;
            if (n > TIMEOUT) fail_now("anode never reached the expected digit");
        end
    endtask

    task automatic check_digits(input logic [5:0] fb);
        wait_anode(4'b0111);
        check_value("digit 3", seg_code(fb[5:3]), seg); // exact
        wait_anode(4'b1011);
        check_value("digit 2", seg_code(fb[2:0]), seg); // partial
    endtask

    task automatic test_registers();
        logic [31:0] rd;
        test_name = "registers";
        rng = xorshift32(rng);
        axi_write(`MM_REG_CODE, {20'b0, rng[11:0]});
        axi_read(`MM_REG_CODE, rd);
        check_value("code", {20'b0, rng[11:0]}, rd);
        axi_read(`MM_REG_STATUS, rd);
        check_value("status", 32'd0, rd);
        axi_read(`MM_REG_CTRL, rd);
        check_value("ctrl", 32'h4, rd); // blink on from reset
    endtask

    task automatic test_editing();
        int keys [14] = '{K_DOWN, K_UP, K_UP, K_LEFT, K_DOWN, K_DOWN, K_RIGHT,
                          K_RIGHT, K_UP, K_RIGHT, K_UP, K_UP, K_LEFT, K_DOWN};
        test_name = "editing";
        axi_write(`MM_REG_CTRL, 32'h0); // blink off
        check_leds(guess_m);
        foreach (keys[i]) begin
            press_key(keys[i]);
            check_leds(guess_m);
        end
    endtask

    task automatic test_scoring(input logic [11:0] code);
        logic [31:0] rd;
        logic [11:0] g;
        logic [5:0]  fb;
        test_name = "scoring";
        axi_write(`MM_REG_CODE, {20'b0, code});
        axi_write(`MM_REG_CTRL, 32'h1);  // new game, blink stays off
        guess_m  = '0;
        cursor_m = '0;
        for (int k = 0; k < 6; k++) begin
            rng = xorshift32(rng);
            g   = (rng[11:0] == code) ? rng[11:0] ^ 12'h1 : rng[11:0];
            enter_guess(g);
            fb = ref_score(g, code);
            press_key(K_SEL);
            axi_read(`MM_REG_STATUS, rd);
            check_value("status", {20'b0, 3'(k + 1), fb, 3'b000}, rd);
            check_digits(fb);
            check_value("turn leds", 8'b1 << (k + 1), sw_led);
        end
    endtask

    task automatic test_win_loss(input logic [11:0] code);
        logic [31:0] rd;
        logic [11:0] g;
        test_name = "win_loss";
        enter_guess(code);
        press_key(K_SEL);
        axi_read(`MM_REG_STATUS, rd);
        check_value("won status", {20'b0, 3'd7, 3'd4, 3'd0, 3'b101}, rd);
        enter_guess(code ^ 12'h3);
        press_key(K_SEL);                 // ignored once over
        axi_read(`MM_REG_STATUS, rd);
        check_value("status after end", {20'b0, 3'd7, 3'd4, 3'd0, 3'b101}, rd);
        axi_write(`MM_REG_CTRL, 32'h1);
        guess_m  = '0;
        cursor_m = '0;
        axi_read(`MM_REG_STATUS, rd);
        check_value("new game status", 32'd0, rd);
        for (int k = 0; k < 8; k++) begin
            rng = xorshift32(rng);
            g   = (rng[11:0] == code) ? rng[11:0] ^ 12'h8 : rng[11:0];
            enter_guess(g);
            hist_g[k] = g;
            hist_f[k] = ref_score(g, code);
            press_key(K_SEL);
            axi_read(`MM_REG_STATUS, rd);
            // turn stops on the last slot
            check_value("loss status", {20'b0, 3'((k == 7) ? 7 : k + 1), hist_f[k],
                                        (k == 7) ? 3'b011 : 3'b000}, rd);
        end
    endtask

    task automatic test_history();
        logic [31:0] rd;
        int          rev;
        test_name = "history";
        for (int t = 0; t < 8; t++) begin
            axi_write(`MM_REG_HIST_SEL, t);
            axi_read(`MM_REG_HIST_DATA, rd);
            check_value("hist data", {14'b0, hist_f[t], hist_g[t]}, rd);
        end
        sw  = 1'b1;  // browse mode
        rev = 0;
        next_cycle();
        check_leds(hist_g[0]);
        check_digits(hist_f[0]);
        for (int i = 0; i < 8; i++) begin
            press_key(K_UP);
            if (rev < 7) rev++;            // stops at the last turn
            check_leds(hist_g[rev]);
        end
        for (int i = 0; i < 8; i++) begin
            press_key(K_DOWN);
            if (rev > 0) rev--;
            check_leds(hist_g[rev]);
            check_digits(hist_f[rev]);
        end
        sw = 1'b0;
    endtask

    task automatic test_lfsr();
        logic [31:0] rd;
        test_name = "lfsr";
        axi_write(`MM_REG_CTRL, 32'h3); // new game from the lfsr
        guess_m  = '0;
        cursor_m = '0;
        axi_read(`MM_REG_CTRL, rd);
        check_value("ctrl", 32'h2, rd);
        axi_read(`MM_REG_CODE, rd);
        check_value("code upper bits", 32'd0, {12'b0, rd[31:12]});
        enter_guess(rd[11:0]);
        press_key(K_SEL);
        axi_read(`MM_REG_STATUS, rd);
        check_value("won status", {20'b0, 3'd1, 3'd4, 3'd0, 3'b101}, rd);
    endtask

    initial begin
        logic [11:0] code;
        int          n;
        rng       = 32'h4b53;
        test_name = "reset";
        sw        = 1'b0;
        btn       = '0;
        s_awaddr  = '0;
        s_awvalid = 1'b0;
        s_wdata   = '0;
        s_wvalid  = 1'b0;
        s_bready  = 1'b0;
        s_araddr  = '0;
        s_arvalid = 1'b0;
        s_rready  = 1'b0;
        guess_m   = '0;
        cursor_m  = '0;
        n = 0;
        do begin
            next_cycle();
            n++;
            if (n > TIMEOUT) fail_now("reset never released");
        end while (!arst_n);
        check_value("anodes off", 32'hF, an);
        test_registers();
        test_editing();
        rng  = xorshift32(rng);
        code = rng[11:0];
        test_scoring(code);
        test_win_loss(code);
        test_history();
        test_lfsr();
        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+include
design/mastermind_pkg.sv
design/button_pulse.sv
design/guess_entry.sv
design/game_regs.sv
design/game_core.sv
design/display_driver.sv
design/mastermind.sv
sim/tb_clock.sv
sim/tb_mastermind.sv
